// ==== hdl/knight_pkg.sv ====
// Knight robot command processor shared types.
// Opcodes, sequencer states, command and sensor structs, ramp and nudge constants.

package knight_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths.
  //////////////////////////////////////////////////////////////////////
  localparam int FRWRD_W = 10;                         // Forward speed width.
  localparam int HDG_W   = 12;                         // Heading and error width.

  //////////////////////////////////////////////////////////////////////
  // Speed ramp steps and heading nudges, fast and hardware sets.
  //////////////////////////////////////////////////////////////////////
  localparam logic [FRWRD_W-1:0] INC_FAST = 10'h020;   // Accel step in simulation.
  localparam logic [FRWRD_W-1:0] INC_SLOW = 10'h003;   // Accel step on the robot.
  localparam logic [FRWRD_W-1:0] DEC_FAST = 10'h040;   // Decel step in simulation.
  localparam logic [FRWRD_W-1:0] DEC_SLOW = 10'h006;   // Decel step on the robot.

  localparam logic signed [HDG_W-1:0] NUDGE_FAST = 12'sh1FF;  // Left IR nudge, simulation.
  localparam logic signed [HDG_W-1:0] NUDGE_SLOW = 12'sh05F;  // Left IR nudge, robot.

  localparam logic [HDG_W-1:0] ALIGN_TOL = 12'h02C;    // Error magnitude counted as aligned.

  //////////////////////////////////////////////////////////////////////
  // Enums.
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    CAL     = 4'h2,                                    // Gyro calibration.
    MOV     = 4'h4,                                    // Plain move.
    FANFARE = 4'h5,                                    // Move with the charge tune.
    TOUR    = 4'h6                                     // Hand off to the tour sequencer.
  } op_t;

  typedef enum logic [2:0] {IDLE, CALIBRATE, ALIGN, ACCEL, DECEL} state_t;

  //////////////////////////////////////////////////////////////////////
  // Structs.
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    op_t        op;                                    // Opcode in the top nibble.
    logic [7:0] hdg;                                   // Coarse heading.
    logic [3:0] squares;                               // Squares to travel.
  } cmd_t;

  typedef struct packed {
    logic lft;                                         // Drifted onto the left line.
    logic cntr;                                        // Crossing a square edge.
    logic rght;                                        // Drifted onto the right line.
  } ir_t;

  typedef struct packed {
    logic clr;                                         // Zero the forward speed.
    logic inc;                                         // Ramp up on gyro updates.
    logic dec;                                         // Ramp down on gyro updates.
  } ramp_ctrl_t;

endpackage

// ==== hdl/speed_ramp.sv ====
// Forward speed ramp.
// Clears, accelerates to saturation and decelerates to zero on gyro updates.
`timescale 1ns/100ps

module speed_ramp #(
  parameter bit fast_sim = 1'b1                        // Pick the simulation step set.
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  knight_pkg::ramp_ctrl_t           ramp,       // Commands from the sequencer.
  input  logic                             heading_rdy, // New gyro sample strobe.
  output logic [knight_pkg::FRWRD_W-1:0]   frwrd,      // Forward speed to the PID.
  output logic                             at_zero     // Speed is fully ramped down.
);

  import knight_pkg::*;

  logic [FRWRD_W-1:0] inc_amt;                         // Step used while accelerating.
  logic [FRWRD_W-1:0] dec_amt;                         // Step used while decelerating.
  logic               max_spd;                         // Top two bits set, stop adding.

  assign inc_amt = fast_sim ? INC_FAST : INC_SLOW;
  assign dec_amt = fast_sim ? DEC_FAST : DEC_SLOW;
  assign max_spd = &frwrd[FRWRD_W-1:FRWRD_W-2];
  assign at_zero = (frwrd == '0);

  //////////////////////////////////////////////////////////////////////
  // Speed register, steps only on a gyro update.
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frwrd <= '0;
    end else if (ramp.clr) begin
      frwrd <= '0;                                     // Fresh start of a move.
    end else if (heading_rdy) begin
      if (ramp.inc && !max_spd) begin
        frwrd <= frwrd + inc_amt;                      // Accelerate.
      end else if (ramp.dec) begin
        // Clamp so the speed never wraps below zero.
        frwrd <= (frwrd < dec_amt) ? '0 : frwrd - dec_amt;
      end
    end
  end

  // Sequencer must never ask for both directions at once.
  a_inc_dec_excl : assert property (@(posedge clk) disable iff (!rst_n)
    !(ramp.inc && ramp.dec));

endmodule

// ==== hdl/square_counter.sv ====
// Square counter on the centre line sensor.
// Counts rising edges and flags when the commanded squares are crossed.
`timescale 1ns/100ps

module square_counter (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cntr,                             // Centre IR level.
  input  logic       move_start,                       // Load squares, clear count.
  input  logic [3:0] squares,                          // Squares from the command.
  output logic       move_done                         // Commanded distance covered.
);

  logic       cntr_prev;                               // Last sample of cntr.
  logic [3:0] sq_lat;                                  // Squares for this move.
  logic [4:0] edge_cnt;                                // Rising edges seen so far.
  logic       rise;                                    // Rising edge this cycle.

  assign rise = cntr & ~cntr_prev;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cntr_prev <= 1'b0;
    end else begin
      cntr_prev <= cntr;                               // Edge detect history.
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Latch the squares and count edges, two per square.
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sq_lat   <= '0;
      edge_cnt <= '0;
    end else if (move_start) begin
      sq_lat   <= squares;                             // New move.
      edge_cnt <= '0;
    end else if (rise) begin
      edge_cnt <= edge_cnt + 5'd1;                     // Visible one cycle after the edge.
    end
  end

  assign move_done = (edge_cnt == {sq_lat, 1'b0});     // Each square has two lines.

endmodule

// ==== hdl/heading_error.sv ====
// Heading error for the PID.
// Latches the desired heading, adds the line-sensor nudge and flags alignment.
`timescale 1ns/100ps

module heading_error #(
  parameter bit fast_sim = 1'b1                        // Pick the simulation nudge.
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  move_start, // Latch a new heading.
  input  logic [7:0]                            hdg,        // Coarse heading field.
  input  logic signed [knight_pkg::HDG_W-1:0]   heading,    // Gyro heading.
  input  knight_pkg::ir_t                       ir,         // Line sensors.
  output logic signed [knight_pkg::HDG_W-1:0]   error,      // Error to the PID.
  output logic                                  aligned     // Close enough to start driving.
);

  import knight_pkg::*;

  logic signed [HDG_W-1:0] desired_hdg;                // Heading the move aims at.
  logic signed [HDG_W-1:0] nudge_mag;                  // Positive nudge for this build.
  logic signed [HDG_W-1:0] nudge;                      // Applied nudge.
  logic        [HDG_W-1:0] err_mag;                    // Magnitude of error.

  //////////////////////////////////////////////////////////////////////
  // Desired heading, zero stays zero, else pad with ones.
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      desired_hdg <= '0;
    end else if (move_start) begin
      desired_hdg <= (hdg == 8'h00) ? '0 : {hdg, 4'hF};  // Centre of the sector.
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Nudge and error.
  //////////////////////////////////////////////////////////////////////
  assign nudge_mag = fast_sim ? NUDGE_FAST : NUDGE_SLOW;

  always_comb begin
    if (ir.lft) begin
      nudge = nudge_mag;                               // Left wins a tie.
    end else if (ir.rght) begin
      nudge = -nudge_mag;
    end else begin
      nudge = '0;
    end
  end

  assign error   = heading - desired_hdg + nudge;
  assign err_mag = error[HDG_W-1] ? -error : error;   // Full negative maps to 0x800.
  assign aligned = (err_mag < ALIGN_TOL);

endmodule

// ==== hdl/cmd_fsm.sv ====
// Command sequencer.
// Decodes opcodes and walks the calibrate and move sequences, all strobes Mealy.
`timescale 1ns/100ps

module cmd_fsm (
  input  logic                    clk,
  input  logic                    rst_n,
  input  knight_pkg::cmd_t        cmd,                 // Command word from the link.
  input  logic                    cmd_rdy,             // Command waiting, level.
  input  logic                    cal_done,            // Gyro calibration finished.
  input  logic                    move_done,           // Squares crossed.
  input  logic                    aligned,             // Heading within tolerance.
  input  logic                    at_zero,             // Speed back at zero.
  output logic                    clr_cmd_rdy,         // Consume the command.
  output logic                    strt_cal,            // Kick off gyro calibration.
  output logic                    send_resp,           // Reply to the link.
  output logic                    tour_go,             // Start the tour sequencer.
  output logic                    fanfare_go,          // Start the charge tune.
  output logic                    moving,              // Robot is under way.
  output logic                    move_start,          // Latch heading and squares.
  output knight_pkg::ramp_ctrl_t  ramp                 // Speed ramp commands.
);

  import knight_pkg::*;

  state_t state;                                       // Current state.
  state_t nxt_state;                                   // Next state.
  logic   fanfare;                                     // This move ends with a tune.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= nxt_state;
    end
  end

  // Remember the move flavour, the command word may change mid move.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fanfare <= 1'b0;
    end else if (move_start) begin
      fanfare <= (cmd.op == FANFARE);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Next state and strobes.
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    nxt_state   = state;
    clr_cmd_rdy = 1'b0;
    strt_cal    = 1'b0;
    send_resp   = 1'b0;
    tour_go     = 1'b0;
    fanfare_go  = 1'b0;
    moving      = 1'b0;
    move_start  = 1'b0;
    ramp        = '0;

    case (state)
      IDLE: begin
        if (cmd_rdy) begin
          clr_cmd_rdy = 1'b1;                          // Every opcode is consumed.
          case (cmd.op)
            CAL: begin
              strt_cal  = 1'b1;
              nxt_state = CALIBRATE;
            end
            TOUR: begin
              tour_go = 1'b1;                          // No response for a tour.
            end
            MOV, FANFARE: begin
              move_start = 1'b1;
              nxt_state  = ALIGN;
            end
            default: begin
              nxt_state = IDLE;                        // Unknown opcode, drop it.
            end
          endcase
        end
      end

      CALIBRATE: begin
        if (cal_done) begin
          send_resp = 1'b1;
          nxt_state = IDLE;
        end
      end

      ALIGN: begin
        moving = 1'b1;                                 // Turning in place counts.
        if (aligned) begin
          ramp.clr  = 1'b1;
          nxt_state = ACCEL;
        end
      end

      ACCEL: begin
        moving   = 1'b1;
        ramp.inc = 1'b1;
        if (move_done) begin
          fanfare_go = fanfare;
          nxt_state  = DECEL;
        end
      end

      DECEL: begin
        ramp.dec = 1'b1;
        if (at_zero) begin
          send_resp = 1'b1;                            // Stopped, move complete.
          nxt_state = IDLE;
        end else begin
          moving = 1'b1;
        end
      end

      default: nxt_state = IDLE;
    endcase
  end

  a_clr_needs_rdy : assert property (@(posedge clk) disable iff (!rst_n)
    clr_cmd_rdy |-> cmd_rdy);

  // One command kicks off at most one action.
  a_one_start : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({strt_cal, tour_go, move_start}));

endmodule

// ==== hdl/cmd_proc.sv ====
// Knight robot command processor top level.
// Wires the sequencer, speed ramp, square counter and heading error together.
`timescale 1ns/100ps

module cmd_proc #(
  parameter bit fast_sim = 1'b1                        // Fast ramp and nudge for simulation.
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  knight_pkg::cmd_t                      cmd,        // Command from the link.
  input  logic                                  cmd_rdy,    // Command waiting.
  output logic                                  clr_cmd_rdy, // Command consumed.
  output logic                                  send_resp,  // Reply to the link.
  output logic                                  strt_cal,   // Start gyro calibration.
  input  logic                                  cal_done,   // Gyro calibration done.
  input  logic signed [knight_pkg::HDG_W-1:0]   heading,    // Gyro heading.
  input  logic                                  heading_rdy, // Gyro sample strobe.
  input  knight_pkg::ir_t                       ir,         // Line sensors.
  output logic signed [knight_pkg::HDG_W-1:0]   error,      // Heading error to the PID.
  output logic [knight_pkg::FRWRD_W-1:0]        frwrd,      // Forward speed to the PID.
  output logic                                  moving,     // Under way, gates yaw.
  output logic                                  tour_go,    // Start the tour.
  output logic                                  fanfare_go  // Start the charge tune.
);

  import knight_pkg::*;

  ramp_ctrl_t ramp;                                    // Sequencer to speed ramp.
  logic       move_start;                              // New move latch pulse.
  logic       move_done;                               // Squares crossed.
  logic       aligned;                                 // Heading within tolerance.
  logic       at_zero;                                 // Speed back at zero.

  //////////////////////////////////////////////////////////////////////
  // Sequencer.
  //////////////////////////////////////////////////////////////////////
  cmd_fsm cmd_fsm_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_rdy     (cmd_rdy),
    .cal_done    (cal_done),
    .move_done   (move_done),
    .aligned     (aligned),
    .at_zero     (at_zero),
    .clr_cmd_rdy (clr_cmd_rdy),
    .strt_cal    (strt_cal),
    .send_resp   (send_resp),
    .tour_go     (tour_go),
    .fanfare_go  (fanfare_go),
    .moving      (moving),
    .move_start  (move_start),
    .ramp        (ramp)
  );

  //////////////////////////////////////////////////////////////////////
  // Datapath blocks.
  //////////////////////////////////////////////////////////////////////
  speed_ramp #(.fast_sim(fast_sim)) speed_ramp_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .ramp        (ramp),
    .heading_rdy (heading_rdy),
    .frwrd       (frwrd),
    .at_zero     (at_zero)
  );

  square_counter square_counter_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cntr       (ir.cntr),
    .move_start (move_start),
    .squares    (cmd.squares),
    .move_done  (move_done)
  );

  heading_error #(.fast_sim(fast_sim)) heading_error_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .move_start (move_start),
    .hdg        (cmd.hdg),
    .heading    (heading),
    .ir         (ir),
    .error      (error),
    .aligned    (aligned)
  );

endmodule

// ==== tb/clk_gen.sv ====
// Testbench clock and reset.
// Free running clock, reset held low for a set number of cycles.
`timescale 1ns/100ps

module clk_gen #(
  parameter int period_ns  = 8,                        // Clock period.
  parameter int rst_cycles = 10                        // Cycles with reset low.
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // Release just after an edge, like every other input.
  initial begin
    rst_n = 1'b0;
    repeat (rst_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

// ==== tb/cmd_proc_tb.sv ====
// Testbench for the knight command processor.
// Sensor models drive the DUT, a reference model checks every cycle.
`timescale 1ns/100ps

module cmd_proc_tb;

  import knight_pkg::*;

  localparam int CLK_PERIOD = 8;                       // ns.
  localparam int DRIVE_DLY  = 1;                       // Input skew after the rising edge.
  localparam int MAX_CYCLES = 25_000;                  // Seven commands of about 1k cycles at most.

  logic                    clk;
  logic                    rst_n;
  cmd_t                    cmd;
  logic                    cmd_rdy;
  logic                    cal_done;
  logic signed [HDG_W-1:0] heading;
  logic                    heading_rdy;
  ir_t                     ir;
  logic                    clr_cmd_rdy;
  logic                    send_resp;
  logic                    strt_cal;
  logic                    moving;
  logic                    tour_go;
  logic                    fanfare_go;
  logic signed [HDG_W-1:0] error;
  logic [FRWRD_W-1:0]      frwrd;

  // Reference model state for the next rising edge.
  state_t                  m_state = IDLE;
  logic signed [HDG_W-1:0] m_des   = '0;             // Desired heading.
  logic [FRWRD_W-1:0]      m_frwrd = '0;
  logic [4:0]              m_cnt   = '0;             // Rising cntr edges.
  logic [3:0]              m_sq    = '0;
  logic                    m_cprev = 1'b0;
  logic                    m_fan   = 1'b0;

  string test_name = "reset";
  int    fan_seen  = 0;                                // fanfare_go pulses so far.
  int    resp_seen = 0;                                // send_resp pulses so far.
  int    gyro_gap  = 0;
  int    line_gap  = 0;

  clk_gen #(.period_ns(CLK_PERIOD), .rst_cycles(10)) clk_gen_i (.clk(clk), .rst_n(rst_n));

  cmd_proc #(.fast_sim(1'b1)) cmd_proc_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_rdy     (cmd_rdy),
    .clr_cmd_rdy (clr_cmd_rdy),
    .send_resp   (send_resp),
    .strt_cal    (strt_cal),
    .cal_done    (cal_done),
    .heading     (heading),
    .heading_rdy (heading_rdy),
    .ir          (ir),
    .error       (error),
    .frwrd       (frwrd),
    .moving      (moving),
    .tour_go     (tour_go),
    .fanfare_go  (fanfare_go)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference functions.
  //////////////////////////////////////////////////////////////////////
  function automatic logic signed [HDG_W-1:0] desired_heading(input logic [7:0] h);
    return (h == 8'h00) ? '0 : {h, 4'hF};              // Middle of the coarse sector.
  endfunction

  function automatic logic signed [HDG_W-1:0] expected_error(
    input logic signed [HDG_W-1:0] hd, input logic signed [HDG_W-1:0] des, input ir_t s);
    logic signed [HDG_W-1:0] n;
    n = s.lft ? NUDGE_FAST : (s.rght ? -NUDGE_FAST : '0);
    return hd - des + n;
  endfunction

  function automatic logic within_tol(input logic signed [HDG_W-1:0] e);
    logic [HDG_W-1:0] mag;
    mag = e[HDG_W-1] ? -e : e;
    return mag < ALIGN_TOL;
  endfunction

  function automatic logic [FRWRD_W-1:0] next_speed(
    input logic [FRWRD_W-1:0] f, input ramp_ctrl_t r, input logic hrdy);
    if (r.clr) return '0;
    if (!hrdy) return f;                               // Speed only moves on a gyro sample.
    if (r.inc) return (f[FRWRD_W-1] && f[FRWRD_W-2]) ? f : f + INC_FAST;
    if (r.dec) return (f < DEC_FAST) ? '0 : f - DEC_FAST;
    return f;
  endfunction

  task automatic check_val(input string what, input int exp_v, input int act_v);
    assert (exp_v == act_v) else begin
      $display("Fail %s: %s expected %0h actual %0h", test_name, what, exp_v, act_v);
      $display("SIMULATION FAILED");
      $fatal(1, "Output mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare at the falling edge and step the model.
  //////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin : compare
    logic signed [HDG_W-1:0] e_err;
    logic                    e_clr;
    logic                    e_cal;
    logic                    e_resp;
    logic                    e_tour;
    logic                    e_fan;
    logic                    e_mov;
    logic                    e_start;
    ramp_ctrl_t              e_ramp;
    state_t                  n_state;
    e_err   = expected_error(heading, m_des, ir);
    {e_clr, e_cal, e_resp, e_tour, e_fan, e_mov, e_start} = '0;
    e_ramp  = '0;
    n_state = m_state;
    if (m_state == IDLE && cmd_rdy) begin
      e_clr = 1'b1;                                    // Any opcode is consumed.
      e_cal = (cmd.op == CAL);
      e_tour = (cmd.op == TOUR);
      e_start = (cmd.op == MOV || cmd.op == FANFARE);
      n_state = e_cal ? CALIBRATE : (e_start ? ALIGN : IDLE);
    end else if (m_state == CALIBRATE && cal_done) begin
      e_resp  = 1'b1;
      n_state = IDLE;
    end else if (m_state == ALIGN) begin
      e_mov      = 1'b1;
      e_ramp.clr = within_tol(e_err);
      n_state    = e_ramp.clr ? ACCEL : ALIGN;
    end else if (m_state == ACCEL) begin
      e_mov      = 1'b1;
      e_ramp.inc = 1'b1;
      if (int'(m_cnt) == 2 * int'(m_sq)) begin         // Two lines per square.
        e_fan   = m_fan;
        n_state = DECEL;
      end
    end else if (m_state == DECEL) begin
      e_ramp.dec = 1'b1;
      e_resp     = (m_frwrd == '0);
      e_mov      = !e_resp;
      n_state    = e_resp ? IDLE : DECEL;
    end
    check_val("clr_cmd_rdy", e_clr, clr_cmd_rdy);
    check_val("strt_cal", e_cal, strt_cal);
    check_val("send_resp", e_resp, send_resp);
    check_val("tour_go", e_tour, tour_go);
    check_val("fanfare_go", e_fan, fanfare_go);
    check_val("moving", e_mov, moving);
    check_val("error", e_err, error);
    check_val("frwrd", m_frwrd, frwrd);
    if (fanfare_go) fan_seen++;
    if (send_resp) resp_seen++;
    if (!rst_n) begin
      m_state = IDLE;
      m_des   = '0;
      m_frwrd = '0;
      m_cnt   = '0;
      m_sq    = '0;
      m_cprev = 1'b0;
      m_fan   = 1'b0;
    end else begin
      m_frwrd = next_speed(m_frwrd, e_ramp, heading_rdy);
      if (e_start) begin
        m_des = desired_heading(cmd.hdg);
        m_sq  = cmd.squares;
        m_cnt = '0;
        m_fan = (cmd.op == FANFARE);
      end else if (ir.cntr && !m_cprev) begin
        m_cnt = m_cnt + 5'd1;
      end
      m_cprev = ir.cntr;
      m_state = n_state;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sensor models.
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin : gyro_model
    logic signed [HDG_W-1:0] diff;
    #(DRIVE_DLY);
    diff = m_des - heading;                            // Wraps like the real heading.
    if (gyro_gap == 0) begin
      heading_rdy = 1'b1;
      gyro_gap    = $urandom_range(4, 2);
      if (diff > 16) heading = heading + 16;
      else if (diff < -16) heading = heading - 16;
      else heading = m_des;
    end else begin
      heading_rdy = 1'b0;
      gyro_gap--;
    end
  end

  always @(posedge clk) begin : line_model
    int side_roll;
    #(DRIVE_DLY);
    if (!(m_state inside {ALIGN, ACCEL, DECEL})) begin
      ir       = '0;
      line_gap = 8;
    end else begin
      if (line_gap == 0) line_gap = $urandom_range(40, 12);   // Spacing to the next line.
      else line_gap--;
      side_roll = $urandom_range(31, 0);
      ir.cntr   = (line_gap < 3);                      // Tape is three cycles wide.
      ir.lft    = (side_roll == 0 || side_roll == 2);  // Rare drift to one side or both.
      ir.rght   = (side_roll == 1 || side_roll == 2);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Command tasks and sequence.
  //////////////////////////////////////////////////////////////////////
  task automatic issue_cmd(input op_t op, input logic [7:0] hdg, input logic [3:0] sq);
    @(posedge clk);
    #(DRIVE_DLY);
    cmd     = '{op: op, hdg: hdg, squares: sq};
    cmd_rdy = 1'b1;
    @(negedge clk);
    while (!clr_cmd_rdy) @(negedge clk);
    @(posedge clk);
    #(DRIVE_DLY);
    cmd_rdy = 1'b0;                                    // Consumed on the last edge.
  endtask

  task automatic run_move(input op_t op, input logic [7:0] hdg, input logic [3:0] sq);
    int fan0;
    int resp0;
    fan0  = fan_seen;
    resp0 = resp_seen;
    issue_cmd(op, hdg, sq);
    @(negedge clk);
    while (!send_resp) @(negedge clk);
    repeat (10) @(negedge clk);
    check_val("fanfare_go pulses", (op == FANFARE) ? 1 : 0, fan_seen - fan0);
    check_val("send_resp pulses", 1, resp_seen - resp0);
  endtask

  task automatic expect_silence(input op_t op);
    int resp0;
    resp0 = resp_seen;
    issue_cmd(op, 8'h00, 4'h0);
    repeat (20) @(negedge clk);
    check_val("send_resp pulses", 0, resp_seen - resp0);
  endtask

  initial begin
    cmd         = '0;
    cmd_rdy     = 1'b0;
    cal_done    = 1'b0;
    heading     = '0;
    heading_rdy = 1'b0;
    ir          = '0;
    void'($urandom(21941));
    @(posedge rst_n);
    repeat (5) @(posedge clk);
    test_name = "calibrate";
    issue_cmd(CAL, 8'h00, 4'h0);
    repeat ($urandom_range(30, 5)) @(posedge clk);
    #(DRIVE_DLY);
    cal_done = 1'b1;                                   // Response due in this cycle.
    @(posedge clk);
    #(DRIVE_DLY);
    cal_done = 1'b0;
    test_name = "tour";
    expect_silence(TOUR);
    test_name = "unknown_op";
    expect_silence(op_t'(4'hA));
    test_name = "move_zero_hdg";
    run_move(MOV, 8'h00, 4'h2);
    test_name = "move_hdg";
    run_move(MOV, 8'h40, 4'h3);
    test_name = "fanfare";
    run_move(FANFARE, 8'hC0, 4'h1);
    test_name = "move_return";
    run_move(MOV, 8'h00, 4'h2);
    $display("SIMULATION PASSED");
    $finish;
  end

  initial begin : watchdog
    #(MAX_CYCLES * CLK_PERIOD);
    $display("Timeout: the DUT did not finish the command sequence in time");
    $display("SIMULATION FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== compile.f ====
hdl/knight_pkg.sv
hdl/speed_ramp.sv
hdl/square_counter.sv
hdl/heading_error.sv
hdl/cmd_fsm.sv
hdl/cmd_proc.sv
tb/clk_gen.sv
tb/cmd_proc_tb.sv

// ==== Bender.yml ====
package:
  name: knight_cmd_proc

sources:
  - files:
      - hdl/knight_pkg.sv
      - hdl/speed_ramp.sv
      - hdl/square_counter.sv
      - hdl/heading_error.sv
      - hdl/cmd_fsm.sv
      - hdl/cmd_proc.sv
  - target: simulation
    files:
      - tb/clk_gen.sv
      - tb/cmd_proc_tb.sv
